//--- src.f
hw/csr_pkg.sv
hw/csr_access_if.sv
hw/csr_access_ctrl.sv
hw/csr_file.sv
hw/irq_select.sv
hw/csr_unit.sv
sim/clk_gen.sv
sim/csr_unit_props.sv
sim/csr_unit_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build and run the CSR testbench with Verilator"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module csr_unit_tb -o csr_unit_sim
	./obj_dir/csr_unit_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- sim/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

    typedef enum logic [2:0] {k_csr, k_exc, k_mret, k_irq, k_ack} kind_e;
    typedef struct packed {
        kind_e             kind;
        csr_pkg::csr_op_e  op;
        logic [11:0]       addr;
        logic              killed;
        csr_pkg::priv_e    priv;
        logic [31:0]       arg; // Data, exception code or irq lines
    } entry_t;

    logic clk, reset, read_enable_i, write_enable_i, killed_i;
    logic raise_exception_i, machine_return_i, interrupt_ack_i, interrupt_pending_o;
    csr_pkg::csr_op_e   operation_i;
    csr_pkg::exc_code_e exception_code_i;
    csr_pkg::priv_e     privilege_i;
    logic [11:0] address_i;
    logic [31:0] data_i, out_o, pc_i, instruction_i, irq_i, mtvec_o, mepc_o;

    entry_t      tbl[$];
    logic [31:0] m_reg [logic [11:0]]; // Model of the writable registers
    logic [63:0] cyc_m, inst_m;
    logic [31:0] rng = 32'he32f;
    logic [31:0] irq_bits;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 1000000;

    clk_gen u_clk (.clk_o(clk), .reset_o(reset));
    csr_unit DUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] mask_of(input logic [11:0] a);
        case (a)
            csr_pkg::csr_mstatus: return csr_pkg::MASK_MSTATUS;
            csr_pkg::csr_misa:    return csr_pkg::MASK_MISA;
            csr_pkg::csr_mie:     return csr_pkg::MASK_MIE;
            csr_pkg::csr_mtvec:   return csr_pkg::MASK_MTVEC;
            csr_pkg::csr_mepc:    return csr_pkg::MASK_MEPC;
            default:              return 32'hFFFFFFFF;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        if (m_reg.exists(a)) return m_reg[a];
        if (a == csr_pkg::csr_cycle) return cyc_m[31:0];
        if (a == csr_pkg::csr_instret) return inst_m[31:0];
        return '0; // Identity registers
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic add(input kind_e k, input csr_pkg::csr_op_e op, input logic [11:0] a,
                       input logic kl, input logic [31:0] arg);
        tbl.push_back('{k, op, a, kl, csr_pkg::priv_machine, arg});
    endtask

    task automatic set_idle();
        read_enable_i     <= 1'b0;
        write_enable_i    <= 1'b0;
        killed_i          <= 1'b0;
        raise_exception_i <= 1'b0;
        machine_return_i  <= 1'b0;
        interrupt_ack_i   <= 1'b0;
        operation_i       <= csr_pkg::op_none;
    endtask

    task automatic read_check(input logic [11:0] a, input string name);
        @(posedge clk);
        set_idle();
        read_enable_i <= 1'b1;
        address_i     <= a;
        @(negedge clk);
        check(name, model_read(a), out_o);
    endtask

    task automatic check_regs();
        read_check(csr_pkg::csr_mstatus, "mstatus");
        read_check(csr_pkg::csr_mcause, "mcause");
        read_check(csr_pkg::csr_mepc, "mepc");
        read_check(csr_pkg::csr_mtval, "mtval");
        check("mepc_o", m_reg[csr_pkg::csr_mepc], mepc_o);
    endtask

    // Shared by exception and interrupt entry
    task automatic trap_entry(input logic [31:0] cause, input csr_pkg::priv_e p);
        logic [31:0] s;
        s = m_reg[csr_pkg::csr_mstatus];
        s[csr_pkg::MSTATUS_MPP_LSB +: 2] = p;
        s[csr_pkg::MSTATUS_MPIE_BIT] = s[csr_pkg::MSTATUS_MIE_BIT];
        s[csr_pkg::MSTATUS_MIE_BIT] = 1'b0;
        m_reg[csr_pkg::csr_mstatus] = s;
        m_reg[csr_pkg::csr_mcause] = cause;
    endtask

    task automatic run_csr(input entry_t e);
        logic [31:0] d, old, nv;
        d = (e.arg != 0) ? e.arg : rng;
        rng = xorshift(rng);
        @(posedge clk);
        set_idle();
        read_enable_i  <= 1'b1;
        write_enable_i <= (e.op != csr_pkg::op_none);
        operation_i    <= e.op;
        address_i      <= e.addr;
        data_i         <= d;
        killed_i       <= e.killed;
        @(negedge clk);
        if (e.killed) check("out_o while killed", 32'd0, out_o);
        old = model_read(e.addr);
        if (!e.killed && m_reg.exists(e.addr)) begin
            case (e.op)
                csr_pkg::op_write: nv = d;
                csr_pkg::op_set:   nv = old | d;
                csr_pkg::op_clear: nv = old & ~d;
                default:           nv = old;
            endcase
            m_reg[e.addr] = (nv & mask_of(e.addr)) | (old & ~mask_of(e.addr));
        end
        read_check(e.addr, "out_o");
        check("mtvec_o", m_reg[csr_pkg::csr_mtvec], mtvec_o);
    endtask

    task automatic run_exc(input entry_t e);
        logic [31:0] pc, ins, wd;
        pc = rng & ~32'd3;
        ins = xorshift(rng);
        wd = xorshift(ins);
        rng = xorshift(wd);
        @(posedge clk);
        set_idle();
        raise_exception_i <= 1'b1;
        exception_code_i  <= csr_pkg::exc_code_e'(e.arg[4:0]);
        privilege_i       <= e.priv;
        pc_i              <= pc;
        instruction_i     <= ins;
        // Colliding mcause write that the exception must override
        write_enable_i    <= 1'b1;
        operation_i       <= csr_pkg::op_write;
        address_i         <= csr_pkg::csr_mcause;
        data_i            <= wd;
        trap_entry({27'd0, e.arg[4:0]}, e.priv);
        m_reg[csr_pkg::csr_mepc] = (e.arg[4:0] == 5'd11) ? pc : pc + 32'd4;
        m_reg[csr_pkg::csr_mtval] = (e.arg[4:0] == 5'd2) ? ins : pc;
        check_regs();
    endtask

    task automatic run_irq(input entry_t e);
        logic expect_pend;
        int lat;
        lat = -1;
        @(posedge clk);
        set_idle();
        irq_i <= e.arg;
        irq_bits = e.arg;
        expect_pend = m_reg[csr_pkg::csr_mstatus][csr_pkg::MSTATUS_MIE_BIT]
                      && ((e.arg & m_reg[csr_pkg::csr_mie]) != 0);
        for (int n = 0; n < 6; n++) begin
            @(negedge clk);
            if (interrupt_pending_o && lat < 0) lat = n;
        end
        check("interrupt_pending_o latency", expect_pend ? 32'd2 : 32'hFFFFFFFF, lat);
    endtask

    task automatic run_ack();
        logic [31:0] pc, hit;
        logic [4:0]  code;
        pc = rng & ~32'd3;
        rng = xorshift(rng);
        hit = irq_bits & m_reg[csr_pkg::csr_mie];
        code = hit[11] ? 5'd11 : (hit[3] ? 5'd3 : 5'd7); // External, software, timer
        @(posedge clk);
        set_idle();
        interrupt_ack_i <= 1'b1;
        privilege_i     <= csr_pkg::priv_machine;
        pc_i            <= pc;
        irq_i           <= '0;
        trap_entry({1'b1, 26'd0, code}, csr_pkg::priv_machine);
        m_reg[csr_pkg::csr_mepc] = pc;
        @(posedge clk);
        set_idle();
        @(negedge clk);
        check("interrupt_pending_o", 32'd0, {31'd0, interrupt_pending_o});
        check_regs();
    endtask

    task automatic run_mret();
        @(posedge clk);
        set_idle();
        machine_return_i <= 1'b1;
        m_reg[csr_pkg::csr_mstatus][csr_pkg::MSTATUS_MIE_BIT] =
            m_reg[csr_pkg::csr_mstatus][csr_pkg::MSTATUS_MPIE_BIT];
        check_regs();
    endtask

    // Counter model follows the sampled kill
    always @(posedge clk) begin
        if (reset) begin
            cyc_m = '0;
            inst_m = '0;
        end else begin
            cyc_m = cyc_m + 64'd1;
            if (!killed_i) inst_m = inst_m + 64'd1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [11:0] wr_addrs [8];
        wr_addrs = '{csr_pkg::csr_mstatus, csr_pkg::csr_misa, csr_pkg::csr_mie,
                     csr_pkg::csr_mtvec, csr_pkg::csr_mscratch, csr_pkg::csr_mepc,
                     csr_pkg::csr_mcause, csr_pkg::csr_mtval};
        read_enable_i = 1'b0;
        write_enable_i = 1'b0;
        killed_i = 1'b0;
        raise_exception_i = 1'b0;
        machine_return_i = 1'b0;
        interrupt_ack_i = 1'b0;
        operation_i = csr_pkg::op_none;
        exception_code_i = csr_pkg::exc_instr_misaligned;
        privilege_i = csr_pkg::priv_machine;
        address_i = '0;
        data_i = '0;
        pc_i = '0;
        instruction_i = '0;
        irq_i = '0;
        foreach (wr_addrs[i]) begin
            m_reg[wr_addrs[i]] = '0;
            add(k_csr, csr_pkg::op_write, wr_addrs[i], 1'b0, 32'd0);
            add(k_csr, csr_pkg::op_set, wr_addrs[i], 1'b0, 32'd0);
            add(k_csr, csr_pkg::op_clear, wr_addrs[i], 1'b0, 32'd0);
        end
        m_reg[csr_pkg::csr_misa] = csr_pkg::MISA_RESET;
        add(k_csr, csr_pkg::op_write, csr_pkg::csr_mvendorid, 1'b0, 32'd0);
        add(k_csr, csr_pkg::op_write, csr_pkg::csr_mhartid, 1'b0, 32'd0);
        add(k_csr, csr_pkg::op_write, csr_pkg::csr_mscratch, 1'b1, 32'd0); // Killed
        add(k_csr, csr_pkg::op_none, csr_pkg::csr_cycle, 1'b0, 32'd0);
        add(k_csr, csr_pkg::op_none, csr_pkg::csr_instret, 1'b0, 32'd0);
        add(k_exc, csr_pkg::op_none, 12'h0, 1'b0, 32'd11);
        add(k_exc, csr_pkg::op_none, 12'h0, 1'b0, 32'd2);
        tbl[tbl.size() - 1].priv = csr_pkg::priv_user;
        add(k_exc, csr_pkg::op_none, 12'h0, 1'b0, 32'd5);
        add(k_csr, csr_pkg::op_write, csr_pkg::csr_mie, 1'b0, 32'h888);
        add(k_csr, csr_pkg::op_set, csr_pkg::csr_mstatus, 1'b0, 32'h8);
        add(k_irq, csr_pkg::op_none, 12'h0, 1'b0, 32'h880); // External and timer
        add(k_ack, csr_pkg::op_none, 12'h0, 1'b0, 32'd0);
        add(k_mret, csr_pkg::op_none, 12'h0, 1'b0, 32'd0);
        add(k_csr, csr_pkg::op_clear, csr_pkg::csr_mstatus, 1'b0, 32'h8);
        add(k_irq, csr_pkg::op_none, 12'h0, 1'b0, 32'h8);
        add(k_csr, csr_pkg::op_write, csr_pkg::csr_mtvec, 1'b0, 32'h1234567B);
        add(k_csr, csr_pkg::op_none, csr_pkg::csr_instret, 1'b0, 32'd0);
        limit = 16 + 4 * tbl.size() + 200;

        do @(posedge clk); while (reset);
        foreach (tbl[i]) begin
            case (tbl[i].kind)
                k_csr:   run_csr(tbl[i]);
                k_exc:   run_exc(tbl[i]);
                k_irq:   run_irq(tbl[i]);
                k_ack:   run_ack();
                default: run_mret();
            endcase
        end
        repeat (2) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/csr_unit_props.sv
`timescale 1ns/1ps

module csr_file_props (
    input logic               clk,
    input logic               reset,
    input logic               raise_exception_i,
    input logic               machine_return_i,
    input csr_pkg::exc_code_e exception_code_i,
    input logic [31:0]        mstatus,
    input logic [31:0]        misa,
    input logic [31:0]        mcause
);

    // Trap entry always disables interrupts
    mie_cleared: assert property (@(posedge clk) disable iff (reset)
        raise_exception_i && !machine_return_i |=> !mstatus[csr_pkg::MSTATUS_MIE_BIT])
        else $error("mstatus.MIE still set after exception entry");

    misa_fixed: assert property (@(posedge clk) disable iff (reset)
        (misa & ~csr_pkg::MASK_MISA) == (csr_pkg::MISA_RESET & ~csr_pkg::MASK_MISA))
        else $error("read-only misa bits changed");

    // Exception wins over a CSR write in the same cycle
    exc_over_write: assert property (@(posedge clk) disable iff (reset)
        raise_exception_i && !machine_return_i |=> mcause == {27'd0, $past(exception_code_i)})
        else $error("mcause does not hold the exception code");

endmodule

bind csr_file csr_file_props u_props (
    .clk(clk), .reset(reset), .raise_exception_i(raise_exception_i),
    .machine_return_i(machine_return_i), .exception_code_i(exception_code_i),
    .mstatus(mstatus), .misa(misa), .mcause(mcause)
);

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic reset_o
);

    initial clk_o = 1'b0;
    always #20 clk_o = ~clk_o; // 40 ns period

    initial begin
        reset_o = 1'b1;
        repeat (16) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

//--- hw/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read_enable_i,
    input  logic                  write_enable_i,
    input  logic                  killed_i,
    input  csr_pkg::csr_op_e      operation_i,
    input  logic [11:0]           address_i,
    input  logic [31:0]           data_i,
    output logic [31:0]           out_o,
    input  logic                  raise_exception_i,
    input  logic                  machine_return_i,
    input  csr_pkg::exc_code_e    exception_code_i,
    input  csr_pkg::priv_e        privilege_i,
    input  logic [31:0]           pc_i,
    input  logic [31:0]           instruction_i,
    input  logic [31:0]           irq_i,
    input  logic                  interrupt_ack_i,
    output logic                  interrupt_pending_o,
    output logic [31:0]           mtvec_o,
    output logic [31:0]           mepc_o
);

    logic [31:0]        mip;
    logic [31:0]        mie;
    logic               global_ie;
    csr_pkg::irq_code_e irq_code;

    csr_access_if acc_if ();

    csr_access_ctrl u_access_ctrl (
        .read_enable_i  (read_enable_i),
        .write_enable_i (write_enable_i),
        .killed_i       (killed_i),
        .operation_i    (operation_i),
        .address_i      (address_i),
        .data_i         (data_i),
        .out_o          (out_o),
        .acc            (acc_if.ctrl)
    );

    csr_file u_csr_file (
        .clk               (clk),
        .reset             (reset),
        .acc               (acc_if.bank),
        .killed_i          (killed_i),
        .raise_exception_i (raise_exception_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .exception_code_i  (exception_code_i),
        .privilege_i       (privilege_i),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .mip_i             (mip),
        .irq_code_i        (irq_code),
        .mie_o             (mie),
        .global_ie_o       (global_ie),
        .mtvec_o           (mtvec_o),
        .mepc_o            (mepc_o)
    );

    // Pending request back to the core
    irq_select u_irq_select (
        .clk                 (clk),
        .reset               (reset),
        .irq_i               (irq_i),
        .mie_i               (mie),
        .global_ie_i         (global_ie),
        .interrupt_ack_i     (interrupt_ack_i),
        .mip_o               (mip),
        .irq_code_o          (irq_code),
        .interrupt_pending_o (interrupt_pending_o)
    );

endmodule

//--- hw/irq_select.sv
`timescale 1ns/1ps

module irq_select (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           irq_i,
    input  logic [31:0]           mie_i,
    input  logic                  global_ie_i,
    input  logic                  interrupt_ack_i,
    output logic [31:0]           mip_o,
    output csr_pkg::irq_code_e    irq_code_o,
    output logic                  interrupt_pending_o
);

    logic [31:0] enabled;
    logic        take;

    assign enabled = mip_o & mie_i;

    // No new request while the core is acknowledging
    assign take = global_ie_i && (enabled != '0) && !interrupt_ack_i;

    // Interrupt lines sampled once per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            interrupt_pending_o <= 1'b0;
        end else begin
            interrupt_pending_o <= take;
        end
    end

    // Cause code held for the acknowledge with external first
    always_ff @(posedge clk) begin
        if (take) begin
            if (enabled[11]) begin
                irq_code_o <= csr_pkg::m_ext_int;
            end else if (enabled[3]) begin
                irq_code_o <= csr_pkg::m_sw_int;
            end else if (enabled[7]) begin
                irq_code_o <= csr_pkg::m_tim_int;
            end
        end
    end

endmodule

//--- hw/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                  clk,
    input  logic                  reset,
    csr_access_if.bank            acc,
    input  logic                  killed_i,
    input  logic                  raise_exception_i,
    input  logic                  machine_return_i,
    input  logic                  interrupt_ack_i,
    input  csr_pkg::exc_code_e    exception_code_i,
    input  csr_pkg::priv_e        privilege_i,
    input  logic [31:0]           pc_i,
    input  logic [31:0]           instruction_i,
    input  logic [31:0]           mip_i,
    input  csr_pkg::irq_code_e    irq_code_i,
    output logic [31:0]           mie_o,
    output logic                  global_ie_o,
    output logic [31:0]           mtvec_o,
    output logic [31:0]           mepc_o
);

    logic [31:0] mstatus;
    logic [31:0] misa;
    logic [31:0] mie;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [63:0] cycle;
    logic [63:0] instret;

    assign mie_o       = mie;
    assign global_ie_o = mstatus[csr_pkg::MSTATUS_MIE_BIT];
    assign mtvec_o     = mtvec;
    assign mepc_o      = mepc;

    // Identity registers fall into the read mux default
    always_comb begin
        case (acc.addr)
            csr_pkg::csr_mstatus:  acc.cur_data = mstatus;
            csr_pkg::csr_misa:     acc.cur_data = misa;
            csr_pkg::csr_mie:      acc.cur_data = mie;
            csr_pkg::csr_mtvec:    acc.cur_data = mtvec;
            csr_pkg::csr_mscratch: acc.cur_data = mscratch;
            csr_pkg::csr_mepc:     acc.cur_data = mepc;
            csr_pkg::csr_mcause:   acc.cur_data = mcause;
            csr_pkg::csr_mtval:    acc.cur_data = mtval;
            csr_pkg::csr_mip:      acc.cur_data = mip_i;
            csr_pkg::csr_cycle:    acc.cur_data = cycle[31:0];
            csr_pkg::csr_cycleh:   acc.cur_data = cycle[63:32];
            csr_pkg::csr_instret:  acc.cur_data = instret[31:0];
            csr_pkg::csr_instreth: acc.cur_data = instret[63:32];
            default:               acc.cur_data = '0;
        endcase
    end

    // One update per edge in the order mret, exception, interrupt and CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            misa     <= csr_pkg::MISA_RESET;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (machine_return_i) begin
            mstatus[csr_pkg::MSTATUS_MIE_BIT] <= mstatus[csr_pkg::MSTATUS_MPIE_BIT];
        end else if (raise_exception_i) begin
            mcause <= {1'b0, 26'd0, exception_code_i};
            mstatus[csr_pkg::MSTATUS_MPP_LSB +: 2] <= privilege_i;
            mstatus[csr_pkg::MSTATUS_MPIE_BIT]     <= mstatus[csr_pkg::MSTATUS_MIE_BIT];
            mstatus[csr_pkg::MSTATUS_MIE_BIT]      <= 1'b0;
            // An M-mode ecall returns to itself
            if (exception_code_i == csr_pkg::exc_ecall_m) begin
                mepc <= pc_i;
            end else begin
                mepc <= pc_i + 32'd4;
            end
            if (exception_code_i == csr_pkg::exc_illegal_instr) begin
                mtval <= instruction_i; // Faulting encoding
            end else begin
                mtval <= pc_i;
            end
        end else if (interrupt_ack_i) begin
            mcause <= {1'b1, 26'd0, irq_code_i};
            mstatus[csr_pkg::MSTATUS_MPP_LSB +: 2] <= privilege_i;
            mstatus[csr_pkg::MSTATUS_MPIE_BIT]     <= mstatus[csr_pkg::MSTATUS_MIE_BIT];
            mstatus[csr_pkg::MSTATUS_MIE_BIT]      <= 1'b0;
            mepc <= pc_i; // Interrupted instruction reruns
        end else if (acc.wr_en) begin
            case (acc.addr)
                csr_pkg::csr_mstatus:  mstatus  <= acc.wr_data;
                csr_pkg::csr_misa:     misa     <= acc.wr_data;
                csr_pkg::csr_mie:      mie      <= acc.wr_data;
                csr_pkg::csr_mtvec:    mtvec    <= acc.wr_data;
                csr_pkg::csr_mscratch: mscratch <= acc.wr_data;
                csr_pkg::csr_mepc:     mepc     <= acc.wr_data;
                csr_pkg::csr_mcause:   mcause   <= acc.wr_data;
                csr_pkg::csr_mtval:    mtval    <= acc.wr_data;
                default: ; // Read-only addresses ignore writes
            endcase
        end
    end

    // Performance counters
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle   <= '0;
            instret <= '0;
        end else begin
            cycle <= cycle + 64'd1;
            if (!killed_i) begin
                instret <= instret + 64'd1; // Retired when not killed
            end
        end
    end

endmodule

//--- hw/csr_access_ctrl.sv
`timescale 1ns/1ps

module csr_access_ctrl (
    input  logic              read_enable_i,
    input  logic              write_enable_i,
    input  logic              killed_i,
    input  csr_pkg::csr_op_e  operation_i,
    input  logic [11:0]       address_i,
    input  logic [31:0]       data_i,
    output logic [31:0]       out_o,
    csr_access_if.ctrl        acc
);

    csr_pkg::csr_addr_e addr;
    logic [31:0]        wmask;
    logic [31:0]        merged;

    assign addr     = csr_pkg::csr_addr_e'(address_i);
    assign acc.addr = addr;

    // Writable bits per address
    always_comb begin
        case (addr)
            csr_pkg::csr_mstatus:  wmask = csr_pkg::MASK_MSTATUS;
            csr_pkg::csr_misa:     wmask = csr_pkg::MASK_MISA;
            csr_pkg::csr_mie:      wmask = csr_pkg::MASK_MIE;
            csr_pkg::csr_mtvec:    wmask = csr_pkg::MASK_MTVEC;
            csr_pkg::csr_mepc:     wmask = csr_pkg::MASK_MEPC;
            csr_pkg::csr_mscratch: wmask = '1;
            csr_pkg::csr_mcause:   wmask = '1;
            csr_pkg::csr_mtval:    wmask = '1;
            default:               wmask = '0; // Read-only
        endcase
    end

    always_comb begin
        case (operation_i)
            csr_pkg::op_write: merged = data_i;
            csr_pkg::op_set:   merged = acc.cur_data | data_i;
            csr_pkg::op_clear: merged = acc.cur_data & ~data_i;
            default:           merged = acc.cur_data; // No change
        endcase
    end

    // Bits outside the mask keep their current value
    assign acc.wr_data = (merged & wmask) | (acc.cur_data & ~wmask);

    // Kill gates both directions here and nowhere else
    assign acc.wr_en = write_enable_i & ~killed_i;
    assign out_o     = (read_enable_i && !killed_i) ? acc.cur_data : '0;

endmodule

//--- hw/csr_access_if.sv
`timescale 1ns/1ps

// One CSR access between the access control and the register file
interface csr_access_if;

    csr_pkg::csr_addr_e addr;
    logic [31:0]        cur_data; // Combinational read of addr
    logic               wr_en;
    logic [31:0]        wr_data;  // Already merged and masked

    modport ctrl (
        output addr,
        output wr_en,
        output wr_data,
        input  cur_data
    );

    modport bank (
        input  addr,
        input  wr_en,
        input  wr_data,
        output cur_data
    );

endinterface

//--- hw/csr_pkg.sv
package csr_pkg;

    // Machine-level CSR address map
    typedef enum logic [11:0] {
        csr_mstatus    = 12'h300,
        csr_misa       = 12'h301,
        csr_mie        = 12'h304,
        csr_mtvec      = 12'h305,
        csr_mscratch   = 12'h340,
        csr_mepc       = 12'h341,
        csr_mcause     = 12'h342,
        csr_mtval      = 12'h343,
        csr_mip        = 12'h344,
        csr_cycle      = 12'hC00,
        csr_instret    = 12'hC02,
        csr_cycleh     = 12'hC80,
        csr_instreth   = 12'hC82,
        csr_mvendorid  = 12'hF11,
        csr_marchid    = 12'hF12,
        csr_mimpid     = 12'hF13,
        csr_mhartid    = 12'hF14,
        csr_mconfigptr = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_write = 2'b01,
        op_set   = 2'b10,
        op_clear = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        priv_user       = 2'b00,
        priv_supervisor = 2'b01,
        priv_machine    = 2'b11
    } priv_e;

    // Synchronous exception causes
    typedef enum logic [4:0] {
        exc_instr_misaligned = 5'd0,
        exc_instr_fault      = 5'd1,
        exc_illegal_instr    = 5'd2,
        exc_breakpoint       = 5'd3,
        exc_load_misaligned  = 5'd4,
        exc_load_fault       = 5'd5,
        exc_store_misaligned = 5'd6,
        exc_store_fault      = 5'd7,
        exc_ecall_u          = 5'd8,
        exc_ecall_m          = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        m_sw_int  = 5'd3,
        m_tim_int = 5'd7,
        m_ext_int = 5'd11
    } irq_code_e;

    // Legal write bits
    localparam logic [31:0] MASK_MSTATUS = 32'h007E19AA;
    localparam logic [31:0] MASK_MISA    = 32'h3C000000;
    localparam logic [31:0] MASK_MIE     = 32'h00000888;
    localparam logic [31:0] MASK_MTVEC   = 32'hFFFFFFFC;
    localparam logic [31:0] MASK_MEPC    = 32'hFFFFFFFC;

    localparam logic [31:0] MISA_RESET = 32'h40000100; // RV32I

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11; // Two bits wide

endpackage
